//--- plic.f
plic_cfg_pkg.sv
plic_reg_pkg.sv
plic_gateway.sv
plic_target.sv
plic_regs.sv
plic_top.sv
plic_tb.sv

//--- plic_cfg_pkg.sv
//////////////////////////////////////////////////////////////////////
// Interrupt controller sizing constants and shared source, target
// and priority types
//////////////////////////////////////////////////////////////////////

package plic_cfg_pkg;

  // Source 0 is reserved and means "no interrupt"
  localparam int NumSrc    = 8;
  localparam int NumTarget = 2;

  // Priority 0 never interrupts
  localparam int MaxPrio   = 7;
  localparam int PrioW     = $clog2(MaxPrio + 1);
  localparam int SrcW      = $clog2(NumSrc);

  // Per-source types
  typedef logic [NumSrc-1:0] src_vec_t;
  typedef logic [PrioW-1:0]  prio_t;
  typedef logic [SrcW-1:0]   src_id_t;
  typedef prio_t [NumSrc-1:0] prio_arr_t;

  // Per-target types
  typedef logic [NumTarget-1:0]     tgt_vec_t;
  typedef src_id_t [NumTarget-1:0]  tgt_id_arr_t;
  typedef prio_t [NumTarget-1:0]    tgt_prio_arr_t;
  typedef src_vec_t [NumTarget-1:0] tgt_src_arr_t;

endpackage

//--- plic_gateway.sv
//////////////////////////////////////////////////////////////////////
// Interrupt gateway with level/edge detection, pending bits and
// in-service locks per source
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module plic_gateway (
  input  logic                   clk_i,
  input  logic                   rst_i,

  // Raw sources and detection mode, 0 level 1 edge
  input  plic_cfg_pkg::src_vec_t src_i,
  input  plic_cfg_pkg::src_vec_t le_i,

  // One-hot strobes from the claim/complete register
  input  plic_cfg_pkg::src_vec_t claim_i,
  input  plic_cfg_pkg::src_vec_t complete_i,

  output plic_cfg_pkg::src_vec_t ip_o
);

  import plic_cfg_pkg::*;

  src_vec_t src_q;
  src_vec_t set;
  src_vec_t ip_q;
  src_vec_t ia_q;

  // Previous source level for edge detection
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      src_q <= '0;
    end else begin
      src_q <= src_i;
    end
  end

  // Level sources request while high, edge sources on a rising edge
  assign set = (le_i & src_i & ~src_q) | (~le_i & src_i);

  // Pending and in-service state
  // Requests during service are dropped, no edge counter
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ip_q <= '0;
      ia_q <= '0;
    end else begin
      // Claim wins over a new request in the same cycle
      ip_q <= (ip_q | (set & ~ia_q)) & ~claim_i;
      // Complete releases the lock
      ia_q <= (ia_q | claim_i) & ~complete_i;
    end
  end

  assign ip_o = ip_q;

  // Software claims only what a target could have reported
  claim_pending_a : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (claim_i & ~ip_q) == '0
  );

endmodule

//--- plic_reg_pkg.sv
//////////////////////////////////////////////////////////////////////
// Register bus request/response structs, register map offsets and
// the register-to-hardware struct
//////////////////////////////////////////////////////////////////////

package plic_reg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus structs
  //////////////////////////////////////////////////////////////////////

  // Request, valid for a single cycle
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [11:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  // Response, same cycle as the request
  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  // One priority word per source
  localparam logic [11:0] PrioBase        = 12'h000;
  // Pending bits, read only
  localparam logic [11:0] IpOffset        = 12'h080;
  // 1 selects edge detection
  localparam logic [11:0] LeOffset        = 12'h084;
  // Per-target blocks
  localparam logic [11:0] TargetBase      = 12'h100;
  localparam logic [11:0] TargetStride    = 12'h010;
  localparam logic [11:0] IeOffset        = 12'h000;
  localparam logic [11:0] ThresholdOffset = 12'h004;
  localparam logic [11:0] CcOffset        = 12'h008;
  localparam logic [11:0] MsipOffset      = 12'h00C;

  // Configuration and strobes towards the interrupt logic
  typedef struct packed {
    plic_cfg_pkg::prio_arr_t     prio;
    plic_cfg_pkg::src_vec_t      le;
    plic_cfg_pkg::tgt_src_arr_t  ie;
    plic_cfg_pkg::tgt_prio_arr_t threshold;
    plic_cfg_pkg::tgt_vec_t      msip;
    plic_cfg_pkg::tgt_vec_t      claim_re;
    plic_cfg_pkg::tgt_vec_t      complete_we;
    plic_cfg_pkg::tgt_id_arr_t   complete_id;
  } reg2hw_t;

endpackage

//--- plic_regs.sv
//////////////////////////////////////////////////////////////////////
// Register block with bus decode, configuration registers, read mux
// and claim/complete strobes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module plic_regs #(
  parameter type reg_req_t = plic_reg_pkg::reg_req_t,
  parameter type reg_rsp_t = plic_reg_pkg::reg_rsp_t
) (
  input  logic                      clk_i,
  input  logic                      rst_i,

  // Register bus, answered in the request cycle
  input  reg_req_t                  reg_req_i,
  output reg_rsp_t                  reg_rsp_o,

  // Status from the interrupt logic
  input  plic_cfg_pkg::src_vec_t    ip_i,
  input  plic_cfg_pkg::tgt_id_arr_t cc_id_i,

  output plic_reg_pkg::reg2hw_t     reg2hw_o
);

  import plic_cfg_pkg::*;
  import plic_reg_pkg::*;

  // Byte address of a register inside a target block
  function automatic logic [11:0] tgt_addr(int t, logic [11:0] off);
    return TargetBase + 12'(t) * TargetStride + off;
  endfunction

  // Configuration state
  prio_arr_t     prio_q;
  src_vec_t      le_q;
  tgt_src_arr_t  ie_q;
  tgt_prio_arr_t thr_q;
  tgt_vec_t      msip_q;

  // Decode results
  logic          wr;
  logic          rd;
  logic          hit;
  logic [31:0]   rdata;
  src_vec_t      prio_we;
  logic          le_we;
  tgt_vec_t      ie_we;
  tgt_vec_t      thr_we;
  tgt_vec_t      msip_we;
  tgt_vec_t      claim_re;
  tgt_vec_t      complete_we;

  assign wr = reg_req_i.valid & reg_req_i.write;
  assign rd = reg_req_i.valid & ~reg_req_i.write;

  //////////////////////////////////////////////////////////////////////
  // Address decode and read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    hit         = 1'b0;
    rdata       = '0;
    prio_we     = '0;
    le_we       = 1'b0;
    ie_we       = '0;
    thr_we      = '0;
    msip_we     = '0;
    claim_re    = '0;
    complete_we = '0;
    if (reg_req_i.valid) begin
      // Priorities, word per source
      for (int s = 0; s < NumSrc; s++) begin
        if (reg_req_i.addr == PrioBase + 12'(4 * s)) begin
          hit        = 1'b1;
          rdata      = 32'(prio_q[s]);
          prio_we[s] = wr;
        end
      end
      // Pending is read only, writes dropped quietly
      if (reg_req_i.addr == IpOffset) begin
        hit   = 1'b1;
        rdata = 32'(ip_i);
      end
      if (reg_req_i.addr == LeOffset) begin
        hit   = 1'b1;
        rdata = 32'(le_q);
        le_we = wr;
      end
      // Target blocks
      for (int t = 0; t < NumTarget; t++) begin
        if (reg_req_i.addr == tgt_addr(t, IeOffset)) begin
          hit      = 1'b1;
          rdata    = 32'(ie_q[t]);
          ie_we[t] = wr;
        end
        if (reg_req_i.addr == tgt_addr(t, ThresholdOffset)) begin
          hit       = 1'b1;
          rdata     = 32'(thr_q[t]);
          thr_we[t] = wr;
        end
        // Read claims the current winner, write completes an ID
        if (reg_req_i.addr == tgt_addr(t, CcOffset)) begin
          hit            = 1'b1;
          rdata          = 32'(cc_id_i[t]);
          claim_re[t]    = rd;
          complete_we[t] = wr;
        end
        if (reg_req_i.addr == tgt_addr(t, MsipOffset)) begin
          hit        = 1'b1;
          rdata      = 32'(msip_q[t]);
          msip_we[t] = wr;
        end
      end
    end
  end

  // Response
  always_comb begin
    reg_rsp_o       = '0;
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = reg_req_i.valid & ~hit;
    reg_rsp_o.rdata = rdata;
  end

  //////////////////////////////////////////////////////////////////////
  // Configuration registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_q <= '0;
      le_q   <= '0;
      ie_q   <= '0;
      thr_q  <= '0;
      msip_q <= '0;
    end else begin
      // Source 0 priority stays at zero
      for (int s = 1; s < NumSrc; s++) begin
        if (prio_we[s]) begin
          prio_q[s] <= reg_req_i.wdata[PrioW-1:0];
        end
      end
      if (le_we) begin
        le_q <= reg_req_i.wdata[NumSrc-1:0];
      end
      for (int t = 0; t < NumTarget; t++) begin
        // Enable of source 0 stays at zero
        if (ie_we[t]) begin
          ie_q[t] <= {reg_req_i.wdata[NumSrc-1:1], 1'b0};
        end
        if (thr_we[t]) begin
          thr_q[t] <= reg_req_i.wdata[PrioW-1:0];
        end
        if (msip_we[t]) begin
          msip_q[t] <= reg_req_i.wdata[0];
        end
      end
    end
  end

  // Towards the interrupt logic
  always_comb begin
    reg2hw_o.prio        = prio_q;
    reg2hw_o.le          = le_q;
    reg2hw_o.ie          = ie_q;
    reg2hw_o.threshold   = thr_q;
    reg2hw_o.msip        = msip_q;
    reg2hw_o.claim_re    = claim_re;
    reg2hw_o.complete_we = complete_we;
    // Completed ID from write data, qualified by the strobe
    for (int t = 0; t < NumTarget; t++) begin
      reg2hw_o.complete_id[t] = reg_req_i.wdata[SrcW-1:0];
    end
  end

  // Strobes only come from a live bus request
  strobe_needs_req_a : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !reg_req_i.valid |-> (reg2hw_o.claim_re == '0) && (reg2hw_o.complete_we == '0)
  );

endmodule

//--- plic_target.sv
//////////////////////////////////////////////////////////////////////
// Interrupt target with priority selection over pending and enabled
// sources against a threshold
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module plic_target (
  input  logic                    clk_i,
  input  logic                    rst_i,

  // Pending bits from the gateway and this target's enables
  input  plic_cfg_pkg::src_vec_t  ip_i,
  input  plic_cfg_pkg::src_vec_t  ie_i,

  // Shared priorities and this target's threshold
  input  plic_cfg_pkg::prio_arr_t prio_i,
  input  plic_cfg_pkg::prio_t     threshold_i,

  output logic                    irq_o,
  output plic_cfg_pkg::src_id_t   irq_id_o
);

  import plic_cfg_pkg::*;

  src_vec_t active;
  prio_t    best_prio;
  src_id_t  best_id;

  // Candidates
  assign active = ip_i & ie_i;

  //////////////////////////////////////////////////////////////////////
  // Winner selection
  //////////////////////////////////////////////////////////////////////

  // Strict compare keeps the lowest ID on a tie
  // Start at 0 so priority 0 never wins
  always_comb begin
    best_prio = '0;
    best_id   = '0;
    // Source 0 is reserved
    for (int s = 1; s < NumSrc; s++) begin
      if (active[s] && (prio_i[s] > best_prio)) begin
        best_prio = prio_i[s];
        best_id   = SrcW'(s);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////////////

  // ID shows the winner even when the threshold masks it
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      irq_o    <= 1'b0;
      irq_id_o <= '0;
    end else begin
      irq_o    <= (best_prio > threshold_i);
      irq_id_o <= best_id;
    end
  end

  // A raised interrupt always names a real source
  irq_has_id_a : assert property (
    @(posedge clk_i) disable iff (rst_i)
    irq_o |-> (irq_id_o != '0)
  );

endmodule

//--- plic_tb.sv
//////////////////////////////////////////////////////////////////////
// Interrupt controller testbench with bus tasks, cycle model,
// output comparator and the six test sequences
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module plic_tb;

  import plic_cfg_pkg::*;
  import plic_reg_pkg::*;

  logic          clk;
  logic          rst;
  reg_req_t      reg_req;
  reg_rsp_t      reg_rsp;
  src_vec_t      intr_src;
  tgt_vec_t      irq;
  tgt_id_arr_t   irq_id;
  tgt_vec_t      msip;

  // Model state with the DUT's reset values
  prio_arr_t     m_prio;
  src_vec_t      m_le;
  src_vec_t      m_ip;
  src_vec_t      m_ia;
  src_vec_t      m_src_q;
  tgt_src_arr_t  m_ie;
  tgt_prio_arr_t m_thr;
  tgt_vec_t      m_msip;
  tgt_vec_t      m_irq;
  tgt_id_arr_t   m_id;

  int            errors;
  string         test_name;
  logic [31:0]   seed;
  logic [31:0]   d;
  src_vec_t      pattern;
  src_id_t       claimed[$];

  plic_top plic_top_i (
    .clk_i      (clk),
    .rst_i      (rst),
    .reg_req_i  (reg_req),
    .reg_rsp_o  (reg_rsp),
    .intr_src_i (intr_src),
    .irq_o      (irq),
    .irq_id_o   (irq_id),
    .msip_o     (msip)
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [11:0] tgt_reg(input int t, input logic [11:0] off);
    return TargetBase + 12'(t) * TargetStride + off;
  endfunction

  // Highest priority wins, scanning down so a tie lands on the lower ID
  function automatic src_id_t winner(input src_vec_t ip_v, input src_vec_t ie_v);
    src_id_t best;
    prio_t   best_p;
    best   = '0;
    best_p = '0;
    for (int s = NumSrc - 1; s > 0; s--) begin
      if (ip_v[s] && ie_v[s] && m_prio[s] != 0 && m_prio[s] >= best_p) begin
        best   = SrcW'(s);
        best_p = m_prio[s];
      end
    end
    return best;
  endfunction

  // Expected read data and whether the address is mapped
  function automatic logic [31:0] model_read(input logic [11:0] a, output logic hit);
    logic [31:0] r;
    r   = '0;
    hit = 1'b0;
    if (a < 12'(4 * NumSrc) && a[1:0] == 2'b00) begin
      hit = 1'b1;
      r   = 32'(m_prio[a[4:2]]);
    end
    if (a == IpOffset) begin
      hit = 1'b1;
      r   = 32'(m_ip);
    end
    if (a == LeOffset) begin
      hit = 1'b1;
      r   = 32'(m_le);
    end
    for (int t = 0; t < NumTarget; t++) begin
      if (a == tgt_reg(t, IeOffset)) begin
        hit = 1'b1;
        r   = 32'(m_ie[t]);
      end
      if (a == tgt_reg(t, ThresholdOffset)) begin
        hit = 1'b1;
        r   = 32'(m_thr[t]);
      end
      if (a == tgt_reg(t, CcOffset)) begin
        hit = 1'b1;
        r   = 32'(m_id[t]);
      end
      if (a == tgt_reg(t, MsipOffset)) begin
        hit = 1'b1;
        r   = 32'(m_msip[t]);
      end
    end
    return r;
  endfunction

  task automatic check(input string label, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, label, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Cycle model and output comparator
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : model_update
    src_vec_t    set_v;
    src_vec_t    clm;
    src_vec_t    cmp;
    src_id_t     w;
    logic [31:0] wd;
    if (rst) begin
      m_prio  <= '0;
      m_le    <= '0;
      m_ip    <= '0;
      m_ia    <= '0;
      m_src_q <= '0;
      m_ie    <= '0;
      m_thr   <= '0;
      m_msip  <= '0;
      m_irq   <= '0;
      m_id    <= '0;
    end else begin
      clm   = '0;
      cmp   = '0;
      wd    = reg_req.wdata;
      // Level sources request while high and edge sources on a low to high step
      set_v = (intr_src & ~m_le) | (intr_src & ~m_src_q & m_le);
      for (int t = 0; t < NumTarget; t++) begin
        if (reg_req.valid && reg_req.addr == tgt_reg(t, CcOffset)) begin
          if (reg_req.write) begin
            cmp[wd[SrcW-1:0]] = 1'b1;
          end else begin
            clm[m_id[t]] = 1'b1;
          end
        end
        w = winner(m_ip, m_ie[t]);
        m_id[t]  <= w;
        m_irq[t] <= m_prio[w] > m_thr[t];
        if (reg_req.valid && reg_req.write) begin
          if (reg_req.addr == tgt_reg(t, IeOffset)) begin
            m_ie[t] <= wd[NumSrc-1:0] & ~src_vec_t'(1);
          end
          if (reg_req.addr == tgt_reg(t, ThresholdOffset)) begin
            m_thr[t] <= wd[PrioW-1:0];
          end
          if (reg_req.addr == tgt_reg(t, MsipOffset)) begin
            m_msip[t] <= wd[0];
          end
        end
      end
      // ID 0 is never claimed or completed
      clm[0]  = 1'b0;
      cmp[0]  = 1'b0;
      m_src_q <= intr_src;
      m_ip    <= (m_ip | (set_v & ~m_ia)) & ~clm;
      m_ia    <= (m_ia | clm) & ~cmp;
      if (reg_req.valid && reg_req.write) begin
        // Source 0 priority stays zero
        if (reg_req.addr < 12'(4 * NumSrc) && reg_req.addr[1:0] == 2'b00
            && reg_req.addr[4:2] != 0) begin
          m_prio[reg_req.addr[4:2]] <= wd[PrioW-1:0];
        end
        if (reg_req.addr == LeOffset) begin
          m_le <= wd[NumSrc-1:0];
        end
      end
    end
  end

  // Outputs are stable mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      check("irq_o", 32'(m_irq), 32'(irq));
      check("irq_id_o", 32'(m_id), 32'(irq_id));
      check("msip_o", 32'(m_msip), 32'(msip));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic bus_access(input logic wr, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    logic        hit;
    logic [31:0] exp;
    int          n;
    @(posedge clk);
    reg_req <= '{valid: 1'b1, write: wr, addr: addr, wdata: wdata};
    @(negedge clk);
    n = 0;
    while (reg_rsp.ready !== 1'b1 && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (reg_rsp.ready !== 1'b1) begin
      $display("Bus never answered the access at address %0h", addr);
      errors++;
    end
    exp = model_read(addr, hit);
    check($sformatf("error at %0h", addr), 32'(!hit), 32'(reg_rsp.error));
    if (!wr) begin
      check($sformatf("read %0h", addr), exp, reg_rsp.rdata);
    end
    rdata = reg_rsp.rdata;
    @(posedge clk);
    reg_req <= '0;
  endtask

  task automatic bus_write(input logic [11:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_access(1'b1, addr, wdata, unused);
  endtask

  task automatic bus_read(input logic [11:0] addr, output logic [31:0] rdata);
    bus_access(1'b0, addr, '0, rdata);
  endtask

  task automatic drive_src(input src_vec_t v);
    @(posedge clk);
    intr_src <= v;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic wait_irq(input int t, input logic lvl);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (irq[t] !== lvl && n < 20);
    if (irq[t] !== lvl) begin
      $display("Timed out waiting for irq_o of target %0d to become %0b", t, lvl);
      errors++;
    end
  endtask

  // Claim on target t until it reports no source
  task automatic claim_all(input int t);
    logic [31:0] id;
    for (int k = 0; k < NumSrc; k++) begin
      bus_read(tgt_reg(t, CcOffset), id);
      if (id == 0) begin
        break;
      end
      claimed.push_back(src_id_t'(id));
    end
  endtask

  task automatic complete_all();
    while (claimed.size() > 0) begin
      bus_write(tgt_reg(0, CcOffset), 32'(claimed.pop_front()));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequences
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    reg_req  = '0;
    intr_src = '0;
    errors   = 0;
    seed     = 32'h17c1ceb4;
    idle(4);
    rst <= 1'b0;

    // Read back masked to width
    test_name = "register access";
    for (int s = 0; s < NumSrc; s++) begin
      seed = xorshift(seed);
      bus_write(PrioBase + 12'(4 * s), seed);
      bus_read(PrioBase + 12'(4 * s), d);
    end
    bus_write(PrioBase + 12'h1C, 32'hFFFF_FFFF);
    bus_read(PrioBase + 12'h1C, d);
    check("prio mask", 32'h7, d);
    bus_write(LeOffset, 32'hFFFF_FFFF);
    bus_read(LeOffset, d);
    bus_write(LeOffset, 32'h0);
    // Pending bits ignore the write
    bus_write(IpOffset, 32'hFF);
    bus_read(IpOffset, d);
    for (int t = 0; t < NumTarget; t++) begin
      bus_write(tgt_reg(t, IeOffset), 32'hFFFF_FFFF);
      bus_read(tgt_reg(t, IeOffset), d);
      check("ie mask", 32'hFE, d);
      bus_write(tgt_reg(t, ThresholdOffset), 32'hFF);
      bus_read(tgt_reg(t, ThresholdOffset), d);
      bus_write(tgt_reg(t, MsipOffset), 32'h3);
      bus_read(tgt_reg(t, MsipOffset), d);
      bus_write(tgt_reg(t, MsipOffset), 32'h0);
      bus_write(tgt_reg(t, IeOffset), 32'h0);
      bus_write(tgt_reg(t, ThresholdOffset), 32'h0);
    end
    // Unmapped addresses
    bus_read(12'h200, d);
    bus_read(12'h08C, d);

    // Source 3 as a level source
    test_name = "level gateway";
    bus_write(PrioBase + 12'h0C, 32'h5);
    bus_write(tgt_reg(0, IeOffset), 32'h08);
    drive_src(8'h08);
    wait_irq(0, 1'b1);
    bus_read(tgt_reg(0, CcOffset), d);
    check("claim id", 32'h3, d);
    bus_read(IpOffset, d);
    check("ip after claim", 32'h0, d);
    idle(4);
    bus_read(IpOffset, d);
    bus_write(tgt_reg(0, CcOffset), 32'h3);
    wait_irq(0, 1'b1);
    bus_read(IpOffset, d);
    check("ip after complete", 32'h08, d);
    bus_read(tgt_reg(0, CcOffset), d);
    drive_src(8'h00);
    bus_write(tgt_reg(0, CcOffset), 32'h3);
    idle(3);
    bus_read(IpOffset, d);

    // Random priorities and source sets
    test_name = "arbitration";
    bus_write(tgt_reg(0, IeOffset), 32'hFE);
    for (int round = 0; round < 3; round++) begin
      for (int s = 1; s < NumSrc; s++) begin
        seed = xorshift(seed);
        bus_write(PrioBase + 12'(4 * s), 32'(seed % 7 + 1));
      end
      seed    = xorshift(seed);
      pattern = (seed[7:0] & 8'hFE) | (8'h1 << (seed[10:8] % 7 + 1));
      drive_src(pattern);
      idle(3);
      claim_all(0);
      check("claim count", $countones(pattern), claimed.size());
      bus_read(IpOffset, d);
      check("ip emptied", 32'h0, d);
      drive_src(8'h00);
      complete_all();
    end

    // Winner at the threshold stays quiet
    test_name = "threshold";
    bus_write(tgt_reg(0, IeOffset), 32'h20);
    bus_write(PrioBase + 12'h14, 32'h3);
    bus_write(tgt_reg(0, ThresholdOffset), 32'h3);
    drive_src(8'h20);
    idle(4);
    @(negedge clk);
    check("masked irq", 32'h0, 32'(irq[0]));
    check("masked id", 32'h5, 32'(irq_id[0]));
    bus_write(tgt_reg(0, ThresholdOffset), 32'h2);
    wait_irq(0, 1'b1);
    claim_all(0);
    drive_src(8'h00);
    complete_all();
    bus_write(tgt_reg(0, ThresholdOffset), 32'h0);

    // Source 6 as an edge source
    test_name = "edge gateway";
    bus_write(LeOffset, 32'h40);
    bus_write(PrioBase + 12'h18, 32'h4);
    bus_write(tgt_reg(0, IeOffset), 32'h40);
    drive_src(8'h40);
    drive_src(8'h00);
    idle(2);
    bus_read(IpOffset, d);
    check("ip after pulse", 32'h40, d);
    wait_irq(0, 1'b1);
    bus_read(tgt_reg(0, CcOffset), d);
    check("edge claim id", 32'h6, d);
    // Pulse during service is dropped
    drive_src(8'h40);
    drive_src(8'h00);
    idle(2);
    bus_read(IpOffset, d);
    check("ip in service", 32'h0, d);
    bus_write(tgt_reg(0, CcOffset), 32'h6);
    idle(3);
    bus_read(IpOffset, d);
    bus_write(LeOffset, 32'h0);

    // Overlapping enables on both targets
    test_name = "target enables";
    for (int s = 1; s < NumSrc; s++) begin
      seed = xorshift(seed);
      bus_write(PrioBase + 12'(4 * s), 32'(seed % 7 + 1));
    end
    bus_write(tgt_reg(0, IeOffset), 32'h3E);
    bus_write(tgt_reg(1, IeOffset), 32'hF8);
    drive_src(8'hFE);
    wait_irq(0, 1'b1);
    wait_irq(1, 1'b1);
    claim_all(1);
    bus_read(IpOffset, d);
    claim_all(0);
    check("claim count", 32'h7, claimed.size());
    drive_src(8'h00);
    complete_all();
    idle(3);

    $display("Checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- plic_top.sv
//////////////////////////////////////////////////////////////////////
// Interrupt controller top with register block, gateway and targets
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module plic_top (
  input  logic                      clk_i,
  input  logic                      rst_i,

  // Register bus
  input  plic_reg_pkg::reg_req_t    reg_req_i,
  output plic_reg_pkg::reg_rsp_t    reg_rsp_o,

  // Interrupt sources, bit 0 tied low
  input  plic_cfg_pkg::src_vec_t    intr_src_i,

  // Per-target notification
  output plic_cfg_pkg::tgt_vec_t    irq_o,
  output plic_cfg_pkg::tgt_id_arr_t irq_id_o,
  output plic_cfg_pkg::tgt_vec_t    msip_o
);

  import plic_cfg_pkg::*;
  import plic_reg_pkg::*;

  reg2hw_t  reg2hw;
  src_vec_t ip;
  src_vec_t claim;
  src_vec_t complete;

  //////////////////////////////////////////////////////////////////////
  // Claim/complete conversion
  //////////////////////////////////////////////////////////////////////

  // Claim takes the ID the target currently shows
  always_comb begin
    claim = '0;
    for (int t = 0; t < NumTarget; t++) begin
      if (reg2hw.claim_re[t]) begin
        claim[irq_id_o[t]] = 1'b1;
      end
    end
    // ID 0 means nothing to claim
    claim[0] = 1'b0;
  end

  // Complete takes the ID written by software
  always_comb begin
    complete = '0;
    for (int t = 0; t < NumTarget; t++) begin
      if (reg2hw.complete_we[t]) begin
        complete[reg2hw.complete_id[t]] = 1'b1;
      end
    end
    complete[0] = 1'b0;
  end

  // Software interrupts straight from the register
  assign msip_o = reg2hw.msip;

  //////////////////////////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////////////////////////

  plic_regs #(
    .reg_req_t (reg_req_t),
    .reg_rsp_t (reg_rsp_t)
  ) plic_regs_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .reg_req_i (reg_req_i),
    .reg_rsp_o (reg_rsp_o),
    .ip_i      (ip),
    .cc_id_i   (irq_id_o),
    .reg2hw_o  (reg2hw)
  );

  plic_gateway plic_gateway_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .src_i      (intr_src_i),
    .le_i       (reg2hw.le),
    .claim_i    (claim),
    .complete_i (complete),
    .ip_o       (ip)
  );

  // One selector per target over the shared pending bits
  for (genvar t = 0; t < NumTarget; t++) begin : gen_target
    plic_target plic_target_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ip_i        (ip),
      .ie_i        (reg2hw.ie[t]),
      .prio_i      (reg2hw.prio),
      .threshold_i (reg2hw.threshold[t]),
      .irq_o       (irq_o[t]),
      .irq_id_o    (irq_id_o[t])
    );
  end

  // At most one target claims or completes per bus access
  claim_onehot_a : assert property (
    @(posedge clk_i) disable iff (rst_i) $onehot0(reg2hw.claim_re)
  );
  complete_onehot_a : assert property (
    @(posedge clk_i) disable iff (rst_i) $onehot0(reg2hw.complete_we)
  );

  // Reserved source stays quiet
  src0_tied_m : assume property (
    @(posedge clk_i) disable iff (rst_i) intr_src_i[0] == 1'b0
  );

endmodule
